/* logic/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  imem_addr_t;
    typedef logic [11:0] dmem_addr_t;
    typedef logic [7:0]  char_t;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 4096;

    localparam word_t TEXT_BASE = 32'h0040_0000;
    // top word of the data RAM
    localparam word_t SP_INIT   = 32'h0000_3FFC;

    localparam reg_idx_t REG_CTRL = 5'd27;
    localparam reg_idx_t REG_SP   = 5'd29;
    localparam reg_idx_t REG_RA   = 5'd31;

    // control register request bits
    localparam int CTRL_OUT_BIT  = 1;
    localparam int CTRL_HALT_BIT = 3;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_JR   = 6'h08,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_EQ
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_WRITEBACK, S_OUTPUT, S_HALTED
    } core_state_e;

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/1ns

interface mem_bus_if import mips_pkg::*; ();

    dmem_addr_t addr;
    word_t      wdata;
    logic       we;
    // read data follows addr in the same cycle
    word_t      rdata;

    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

/* logic/alu.sv */
`timescale 1ns/1ns

module alu import mips_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    overflow
);

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;

    assign sum   = a + b;
    assign diff  = a - b;
    // shift amount comes from a, shifted value from b
    assign shamt = a[4:0];

    always_comb begin
        overflow = 1'b0;
        case (op)
            ALU_ADD: begin
                result   = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            ALU_SUB: begin
                result   = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            // branch compare, bit 0 only
            ALU_EQ:   result = {31'b0, a == b};
            default:  result = '0;
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns

module reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_sel,
    input  reg_idx_t rt_sel,
    input  reg_idx_t dbg_sel,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    dbg_data,
    output word_t    ctrl,
    input  logic     we,
    input  reg_idx_t wr_sel,
    input  word_t    wr_data,
    input  logic     ctrl_clear_out,
    input  logic     ctrl_clear_halt
);

    word_t regs [32];

    assign rs_data  = regs[rs_sel];
    assign rt_data  = regs[rt_sel];
    assign dbg_data = regs[dbg_sel];
    assign ctrl     = regs[REG_CTRL];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0]        <= '0;
            regs[REG_SP]   <= SP_INIT;
            regs[REG_CTRL] <= '0;
        end else begin
            // r0 never written, stays zero from reset
            if (we && wr_sel != '0) begin
                regs[wr_sel] <= wr_data;
            end
            if (ctrl_clear_halt) begin
                regs[REG_CTRL][CTRL_HALT_BIT] <= 1'b0;
            end else if (ctrl_clear_out) begin
                regs[REG_CTRL][CTRL_OUT_BIT] <= 1'b0;
            end
        end
    end

endmodule

/* logic/data_memory.sv */
`timescale 1ns/1ns

module data_memory import mips_pkg::*; (
    input logic        clk,
    mem_bus_if.memory  bus
);

    word_t mem [DMEM_WORDS];

    // asynchronous read
    assign bus.rdata = mem[bus.addr];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

endmodule

/* logic/console_out.sv */
`timescale 1ns/1ns

module console_out import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  word_t     base,
    mem_bus_if.master bus,
    output char_t     char_data,
    output logic      char_valid,
    input  logic      char_ready,
    output logic      done
);

    logic       busy;
    dmem_addr_t rd_addr;
    word_t      remain;

    // length word is read straight from base on the start cycle
    assign bus.addr  = start ? base[13:2] : rd_addr;
    assign bus.wdata = '0;
    assign bus.we    = 1'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            char_valid <= 1'b0;
            done       <= 1'b0;
            rd_addr    <= '0;
            remain     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                remain  <= bus.rdata;
                rd_addr <= base[13:2] + 12'd1;
            end else if (busy && (!char_valid || char_ready)) begin
                // first char, or the current one was taken
                if (remain == '0) begin
                    busy       <= 1'b0;
                    char_valid <= 1'b0;
                    done       <= 1'b1;
                end else begin
                    char_data  <= bus.rdata[7:0];
                    char_valid <= 1'b1;
                    rd_addr    <= rd_addr + 12'd1;
                    remain     <= remain - 32'd1;
                end
            end
        end
    end

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ns

module mips_core import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  reg_idx_t   dbg_sel,
    output word_t      dbg_data,
    mem_bus_if.master  dmem,
    output char_t      char_data,
    output logic       char_valid,
    input  logic       char_ready,
    output logic       halted
);

    word_t       imem [IMEM_WORDS];
    word_t       pc;
    word_t       ir;
    core_state_e state;

    alu_op_e alu_op;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_y;
    logic    alu_ovf;
    word_t   alu_q;
    logic    ovf_q;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm_s;
    word_t    imm_z;
    word_t    pc_branch;

    alu_op_e dec_op;
    word_t   dec_a;
    word_t   dec_b;

    reg_idx_t rs_sel;
    word_t    rs_data;
    word_t    rt_data;
    word_t    ctrl;
    logic     rf_we;
    reg_idx_t rf_sel;
    word_t    rf_data;
    logic     clear_out;
    logic     clear_halt;

    logic con_start;
    logic con_done;

    mem_bus_if cbus ();

    assign opcode    = opcode_e'(ir[31:26]);
    assign funct     = funct_e'(ir[5:0]);
    assign rs        = ir[25:21];
    assign rt        = ir[20:16];
    assign rd        = ir[15:11];
    assign imm_s     = {{16{ir[15]}}, ir[15:0]};
    assign imm_z     = {16'b0, ir[15:0]};
    // pc already holds the incremented value here
    assign pc_branch = pc + {imm_s[29:0], 2'b00};

    // streamer reads sp through the rs port while it runs
    assign rs_sel = (state == S_OUTPUT) ? REG_SP : rs;

    assign clear_halt = (state == S_FETCH) && ctrl[CTRL_HALT_BIT];
    assign clear_out  = (state == S_FETCH) && !ctrl[CTRL_HALT_BIT] && ctrl[CTRL_OUT_BIT];

    // console streamer drives the read address during output
    assign dmem.addr   = (state == S_OUTPUT) ? cbus.addr : alu_q[13:2];
    assign dmem.wdata  = rt_data;
    assign dmem.we     = (state == S_WRITEBACK) && (opcode == OP_SW);
    assign cbus.rdata  = dmem.rdata;

    always_comb begin
        dec_op = ALU_ADD;
        dec_a  = rs_data;
        dec_b  = imm_s;
        case (opcode)
            OP_SPECIAL: begin
                dec_b = rt_data;
                case (funct)
                    F_SUB, F_SUBU: dec_op = ALU_SUB;
                    F_AND:         dec_op = ALU_AND;
                    F_OR:          dec_op = ALU_OR;
                    F_XOR:         dec_op = ALU_XOR;
                    F_NOR:         dec_op = ALU_NOR;
                    F_SLT:         dec_op = ALU_SLT;
                    F_SLTU:        dec_op = ALU_SLTU;
                    F_SLLV:        dec_op = ALU_SLL;
                    F_SRLV:        dec_op = ALU_SRL;
                    F_SRAV:        dec_op = ALU_SRA;
                    F_SLL, F_SRL, F_SRA: begin
                        // immediate shifts take shamt from the instruction
                        dec_a  = {27'b0, ir[10:6]};
                        dec_op = (funct == F_SLL) ? ALU_SLL
                               : (funct == F_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    default:       dec_op = ALU_ADD;
                endcase
            end
            OP_SLTI:  dec_op = ALU_SLT;
            OP_SLTIU: dec_op = ALU_SLTU;
            OP_ANDI: begin
                dec_op = ALU_AND;
                dec_b  = imm_z;
            end
            OP_ORI: begin
                dec_op = ALU_OR;
                dec_b  = imm_z;
            end
            OP_XORI: begin
                dec_op = ALU_XOR;
                dec_b  = imm_z;
            end
            OP_LUI: begin
                // lui as imm << 16
                dec_op = ALU_SLL;
                dec_a  = 32'd16;
                dec_b  = imm_z;
            end
            OP_BEQ, OP_BNE: begin
                dec_op = ALU_EQ;
                dec_b  = rt_data;
            end
            default: dec_op = ALU_ADD;
        endcase
    end

    always_comb begin
        rf_we   = 1'b0;
        rf_sel  = rt;
        rf_data = alu_q;
        if (state == S_WRITEBACK) begin
            case (opcode)
                OP_SPECIAL: begin
                    rf_sel = rd;
                    case (funct)
                        F_ADD, F_SUB: rf_we = !ovf_q;
                        F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU,
                        F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV: rf_we = 1'b1;
                        default: rf_we = 1'b0;
                    endcase
                end
                OP_ADDI: rf_we = !ovf_q;
                OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    rf_we = 1'b1;
                end
                OP_LW: begin
                    rf_we   = 1'b1;
                    rf_data = dmem.rdata;
                end
                OP_JAL: begin
                    rf_we   = 1'b1;
                    rf_sel  = REG_RA;
                    rf_data = pc;
                end
                default: rf_we = 1'b0;
            endcase
        end
    end

    // program port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_FETCH;
            pc        <= TEXT_BASE;
            halted    <= 1'b0;
            con_start <= 1'b0;
        end else begin
            con_start <= 1'b0;
            case (state)
                S_FETCH: begin
                    // halt wins over output
                    if (ctrl[CTRL_HALT_BIT]) begin
                        halted <= 1'b1;
                        state  <= S_HALTED;
                    end else if (ctrl[CTRL_OUT_BIT]) begin
                        con_start <= 1'b1;
                        state     <= S_OUTPUT;
                    end else begin
                        ir    <= imem[pc[9:2]];
                        pc    <= pc + 32'd4;
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    alu_op <= dec_op;
                    alu_a  <= dec_a;
                    alu_b  <= dec_b;
                    state  <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    alu_q <= alu_y;
                    ovf_q <= alu_ovf;
                    state <= S_WRITEBACK;
                end
                S_WRITEBACK: begin
                    case (opcode)
                        OP_SPECIAL: if (funct == F_JR) pc <= rs_data;
                        OP_BEQ:     if (alu_q[0]) pc <= pc_branch;
                        OP_BNE:     if (!alu_q[0]) pc <= pc_branch;
                        OP_J, OP_JAL: pc <= {pc[31:28], ir[25:0], 2'b00};
                        default: ;
                    endcase
                    state <= S_FETCH;
                end
                S_OUTPUT: begin
                    if (con_done) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_HALTED;
            endcase
        end
    end

    alu u_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_y),
        .overflow (alu_ovf)
    );

    reg_file u_regs (
        .clk             (clk),
        .reset           (reset),
        .rs_sel          (rs_sel),
        .rt_sel          (rt),
        .dbg_sel         (dbg_sel),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .dbg_data        (dbg_data),
        .ctrl            (ctrl),
        .we              (rf_we),
        .wr_sel          (rf_sel),
        .wr_data         (rf_data),
        .ctrl_clear_out  (clear_out),
        .ctrl_clear_halt (clear_halt)
    );

    console_out u_con (
        .clk        (clk),
        .reset      (reset),
        .start      (con_start),
        .base       (rs_data),
        .bus        (cbus.master),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .done       (con_done)
    );

endmodule

/* logic/mips_top.sv */
`timescale 1ns/1ns

module mips_top import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  reg_idx_t   dbg_sel,
    output word_t      dbg_data,
    output char_t      char_data,
    output logic       char_valid,
    input  logic       char_ready,
    output logic       halted
);

    // core to data RAM
    mem_bus_if dbus ();

    mips_core u_core (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dbg_sel    (dbg_sel),
        .dbg_data   (dbg_data),
        .dmem       (dbus.master),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .halted     (halted)
    );

    data_memory u_dmem (
        .clk (clk),
        .bus (dbus.memory)
    );

endmodule

/* bench/mips_tb.sv */
`timescale 1ns/1ns

module mips_tb import mips_pkg::*; ();

    localparam int CLK_HALF_NS = 10;
    // halt budgets of the five programs, 4N+1 each
    localparam int TEST_CYCLES = 17 + 113 + 37 + 137 + 73;
    localparam int OUT_ALLOW   = 200;
    // program loading and debug register reads
    localparam int LOAD_CYCLES = 400;
    localparam int WATCHDOG_NS = 2 * (TEST_CYCLES + OUT_ALLOW + LOAD_CYCLES) * 2 * CLK_HALF_NS;
    localparam int STR_LEN     = 6;

    logic       clk;
    logic       reset;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    reg_idx_t   dbg_sel;
    word_t      dbg_data;
    char_t      char_data;
    logic       char_valid;
    logic       char_ready;
    logic       halted;

    int    seed;
    int    errors;
    int    tests_run;
    int    tests_ok;
    word_t rnd;
    word_t prog[$];
    char_t got_chars[$];
    logic  collecting;

    mips_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dbg_sel    (dbg_sel),
        .dbg_data   (dbg_data),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .halted     (halted)
    );

    always #(CLK_HALF_NS) clk = ~clk;

    // console characters taken on accepted edges
    always @(posedge clk) begin
        if (collecting && char_valid && char_ready) begin
            got_chars.push_back(char_data);
        end
    end

    function automatic word_t r_format(funct_e f, int rs, int rt, int rd, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
    endfunction

    function automatic word_t i_format(opcode_e op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // target given as instruction index in the program
    function automatic word_t j_format(opcode_e op, int idx);
        word_t addr;
        addr = TEXT_BASE + 4 * idx;
        return {op, addr[27:2]};
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_reg(input string what, input int idx, input word_t exp);
        @(posedge clk);
        #1;
        dbg_sel = 5'(idx);
        @(negedge clk);
        check_value(what, dbg_data, exp);
    endtask

    // load under reset, release, then wait for halted
    task automatic run_program(input int limit, output int cycles);
        int i;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (i = 0; i < prog.size() || i < 2; i++) begin
            @(posedge clk);
            #1;
            prog_we = (i < prog.size());
            prog_addr = 8'(i);
            if (i < prog.size()) begin
                prog_data = prog[i];
            end
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        check_value("halted in reset", {31'b0, halted}, 32'd0);
        check_value("char_valid in reset", {31'b0, char_valid}, 32'd0);
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            rnd = $random(seed);
            char_ready = rnd[0];
        end
        if (!halted) begin
            $display("halted did not rise within %0d cycles at %0t ns", limit, $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) failed", name, errors - start_errors);
        end
    endtask

    task automatic reset_timing_test();
        int start_errors;
        int cycles;
        start_errors = errors;
        prog.delete();
        prog.push_back(i_format(OP_ADDIU, 0, 1, 5));
        prog.push_back(i_format(OP_ADDIU, 0, 2, 7));
        prog.push_back(r_format(F_ADDU, 1, 2, 3, 0));
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 8));
        run_program(4 * prog.size() + 11, cycles);
        check_value("halt latency", cycles, 4 * prog.size() + 1);
        expect_reg("r3", 3, 32'd12);
        report_test("reset and timing", start_errors);
    endtask

    task automatic alu_ops_test();
        int          start_errors;
        int          cycles;
        int          i;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       zimm;
        word_t       exp[32];
        logic [15:0] imm;
        logic [4:0]  sh;
        start_errors = errors;
        // operands kept within +-2^30 so add and sub cannot overflow
        rnd = $random(seed);
        a = {rnd[31], rnd[31:1]};
        rnd = $random(seed);
        b = {rnd[31], rnd[31:1]};
        rnd = $random(seed);
        imm = rnd[15:0];
        sh = rnd[20:16];
        simm = {{16{imm[15]}}, imm};
        zimm = {16'b0, imm};
        prog.delete();
        prog.push_back(i_format(OP_LUI, 0, 1, int'(a[31:16])));
        prog.push_back(i_format(OP_ORI, 1, 1, int'(a[15:0])));
        prog.push_back(i_format(OP_LUI, 0, 2, int'(b[31:16])));
        prog.push_back(i_format(OP_ORI, 2, 2, int'(b[15:0])));
        prog.push_back(r_format(F_ADD, 1, 2, 3, 0));
        prog.push_back(r_format(F_SUB, 1, 2, 4, 0));
        prog.push_back(r_format(F_AND, 1, 2, 5, 0));
        prog.push_back(r_format(F_OR, 1, 2, 6, 0));
        prog.push_back(r_format(F_XOR, 1, 2, 7, 0));
        prog.push_back(r_format(F_NOR, 1, 2, 8, 0));
        prog.push_back(r_format(F_SLT, 1, 2, 9, 0));
        prog.push_back(r_format(F_SLTU, 1, 2, 10, 0));
        prog.push_back(r_format(F_SLL, 0, 2, 11, int'(sh)));
        prog.push_back(r_format(F_SRL, 0, 2, 12, int'(sh)));
        prog.push_back(r_format(F_SRA, 0, 2, 13, int'(sh)));
        prog.push_back(r_format(F_SLLV, 1, 2, 14, 0));
        prog.push_back(r_format(F_SRLV, 1, 2, 15, 0));
        prog.push_back(r_format(F_SRAV, 1, 2, 16, 0));
        prog.push_back(i_format(OP_ADDI, 1, 17, int'(imm)));
        prog.push_back(i_format(OP_ADDIU, 1, 18, int'(imm)));
        prog.push_back(i_format(OP_SLTI, 1, 19, int'(imm)));
        prog.push_back(i_format(OP_SLTIU, 1, 20, int'(imm)));
        prog.push_back(i_format(OP_ANDI, 1, 21, int'(imm)));
        prog.push_back(i_format(OP_ORI, 1, 22, int'(imm)));
        prog.push_back(i_format(OP_XORI, 1, 23, int'(imm)));
        prog.push_back(i_format(OP_LUI, 0, 24, int'(imm)));
        prog.push_back(i_format(OP_ADDIU, 1, 0, 1));
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 8));
        exp[3] = a + b;
        exp[4] = a - b;
        exp[5] = a & b;
        exp[6] = a | b;
        exp[7] = a ^ b;
        exp[8] = ~(a | b);
        exp[9] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exp[10] = (a < b) ? 32'd1 : 32'd0;
        exp[11] = b << sh;
        exp[12] = b >> sh;
        exp[13] = $signed(b) >>> sh;
        exp[14] = b << a[4:0];
        exp[15] = b >> a[4:0];
        exp[16] = $signed(b) >>> a[4:0];
        exp[17] = a + simm;
        exp[18] = a + simm;
        exp[19] = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        exp[20] = (a < simm) ? 32'd1 : 32'd0;
        exp[21] = a & zimm;
        exp[22] = a | zimm;
        exp[23] = a ^ zimm;
        exp[24] = {imm, 16'b0};
        run_program(4 * prog.size() + 11, cycles);
        for (i = 3; i <= 24; i++) begin
            expect_reg($sformatf("r%0d", i), i, exp[i]);
        end
        expect_reg("r0", 0, 32'd0);
        report_test("alu and immediate", start_errors);
    endtask

    task automatic overflow_test();
        int start_errors;
        int cycles;
        start_errors = errors;
        prog.delete();
        prog.push_back(i_format(OP_LUI, 0, 1, 16'h7FFF));
        prog.push_back(i_format(OP_ORI, 1, 1, 16'hFFFF));
        prog.push_back(i_format(OP_ADDIU, 0, 2, 1));
        prog.push_back(i_format(OP_ADDIU, 0, 3, 16'h55));
        prog.push_back(i_format(OP_ADDIU, 0, 4, 16'h66));
        prog.push_back(r_format(F_ADD, 1, 2, 3, 0));
        prog.push_back(i_format(OP_ADDI, 1, 4, 1));
        prog.push_back(r_format(F_ADDU, 1, 2, 5, 0));
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 8));
        run_program(4 * prog.size() + 11, cycles);
        expect_reg("add overflow", 3, 32'h55);
        expect_reg("addi overflow", 4, 32'h66);
        expect_reg("addu wrap", 5, 32'h8000_0000);
        report_test("overflow", start_errors);
    endtask

    task automatic mem_branch_test();
        int    start_errors;
        int    cycles;
        int    i;
        word_t v[3];
        start_errors = errors;
        prog.delete();
        for (i = 0; i < 3; i++) begin
            v[i] = $random(seed);
            prog.push_back(i_format(OP_LUI, 0, i + 1, int'(v[i][31:16])));
            prog.push_back(i_format(OP_ORI, i + 1, i + 1, int'(v[i][15:0])));
        end
        prog.push_back(i_format(OP_SW, REG_SP, 1, -4));
        prog.push_back(i_format(OP_SW, REG_SP, 2, -8));
        prog.push_back(i_format(OP_SW, REG_SP, 3, -64));
        prog.push_back(i_format(OP_LW, REG_SP, 4, -4));
        prog.push_back(i_format(OP_LW, REG_SP, 5, -8));
        prog.push_back(i_format(OP_LW, REG_SP, 6, -64));
        // countdown from 5, loop body at index 14
        prog.push_back(i_format(OP_ADDIU, 0, 7, 5));
        prog.push_back(i_format(OP_ADDIU, 0, 8, 0));
        prog.push_back(i_format(OP_ADDIU, 8, 8, 1));
        prog.push_back(i_format(OP_ADDIU, 7, 7, -1));
        prog.push_back(i_format(OP_BNE, 7, 0, -3));
        prog.push_back(i_format(OP_BEQ, 0, 0, 1));
        prog.push_back(i_format(OP_ADDIU, 8, 8, 100));
        // call at index 19, subroutine at 21
        prog.push_back(j_format(OP_JAL, 21));
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 8));
        prog.push_back(i_format(OP_ADDIU, 0, 10, 77));
        prog.push_back(r_format(F_JR, REG_RA, 0, 0, 0));
        run_program(4 * 34 + 11, cycles);
        expect_reg("lw at sp-4", 4, v[0]);
        expect_reg("lw at sp-8", 5, v[1]);
        expect_reg("lw at sp-64", 6, v[2]);
        expect_reg("loop count", 8, 32'd5);
        expect_reg("subroutine result", 10, 32'd77);
        expect_reg("return address", REG_RA, TEXT_BASE + 4 * 19 + 4);
        report_test("memory and branches", start_errors);
    endtask

    task automatic console_test();
        int    start_errors;
        int    cycles;
        int    i;
        char_t chars[STR_LEN];
        start_errors = errors;
        prog.delete();
        got_chars.delete();
        prog.push_back(i_format(OP_ADDIU, REG_SP, REG_SP, -64));
        prog.push_back(i_format(OP_ADDIU, 0, 1, STR_LEN));
        prog.push_back(i_format(OP_SW, REG_SP, 1, 0));
        for (i = 0; i < STR_LEN; i++) begin
            rnd = $random(seed);
            chars[i] = rnd[7:0];
            prog.push_back(i_format(OP_ADDIU, 0, 2, int'(chars[i])));
            prog.push_back(i_format(OP_SW, REG_SP, 2, 4 * (i + 1)));
        end
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 2));
        prog.push_back(i_format(OP_ADDIU, 0, 3, 16'h33));
        prog.push_back(i_format(OP_ORI, 0, REG_CTRL, 8));
        collecting = 1'b1;
        run_program(4 * prog.size() + 1 + OUT_ALLOW, cycles);
        collecting = 1'b0;
        check_value("char count", got_chars.size(), STR_LEN);
        for (i = 0; i < STR_LEN && i < got_chars.size(); i++) begin
            check_value($sformatf("char %0d", i), {24'b0, got_chars[i]}, {24'b0, chars[i]});
        end
        check_value("char_valid after string", {31'b0, char_valid}, 32'd0);
        expect_reg("r3 after output", 3, 32'h33);
        report_test("console output", start_errors);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_sel = '0;
        char_ready = 1'b0;
        collecting = 1'b0;
        seed = 29264;
        errors = 0;
        tests_run = 0;
        tests_ok = 0;
        reset_timing_test();
        alu_ops_test();
        overflow_test();
        mem_branch_test();
        console_test();
        $display("%0d of %0d tests ok, %0d checks failed", tests_ok, tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out after %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

/* mips_cpu.f */
logic/mips_pkg.sv
logic/mem_bus_if.sv
logic/alu.sv
logic/reg_file.sv
logic/data_memory.sv
logic/console_out.sv
logic/mips_core.sv
logic/mips_top.sv
bench/mips_tb.sv

/* Makefile */
TOP := mips_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_cpu.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
